//--- Bender.yml
package:
  name: ig

export_include_dirs:
  - .

sources:
  - files:
      - ig_pkg.sv
      - pipe_skid.sv
      - img_reader.sv
      - grad_compute.sv
      - grad_writer.sv
      - ig_top.sv
  - target: test
    files:
      - ig_asserts.sv
      - tb_ig.sv

//--- grad_compute.sv
`timescale 1ns/1ns
`default_nettype none

`include "ig_defines.svh"

module grad_compute (
    input  logic           clk,
    input  logic           reset,
    input  logic           pix_valid,
    output logic           pix_ready,
    input  ig_pkg::pixel_t pix_data,
    output logic           gr_valid,
    input  logic           gr_ready,
    output ig_pkg::grad_t  gr_data
);

    localparam int unsigned W       = `IG_IMG_W;
    localparam int unsigned H       = `IG_IMG_H;
    localparam int unsigned NUM_PIX = W * H;
    localparam int unsigned COL_W   = (W > 1) ? $clog2(W) : 1;
    localparam int unsigned ROW_W   = (H > 1) ? $clog2(H) : 1;

    localparam ig_pkg::addr_t LAST_PIX = ig_pkg::addr_t'(NUM_PIX - 1);
    localparam ig_pkg::addr_t FILL_PIX = ig_pkg::addr_t'(W);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(W - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(H - 1);

    // win[0] newest, win[W] oldest
    ig_pkg::pixel_t win [0:W];

    ig_pkg::addr_t    in_cnt;
    logic             win_full;
    logic             drain;
    logic [COL_W-1:0] org_col;
    logic [ROW_W-1:0] org_row;

    logic          pix_fire;
    logic          gr_in_valid;
    logic          gr_in_ready;
    logic          gr_fire;
    ig_pkg::grad_t gr_in_data;

    assign pix_ready   = gr_in_ready && !drain;
    assign pix_fire    = pix_valid && pix_ready;
    assign gr_in_valid = drain || (pix_fire && win_full);
    assign gr_fire     = gr_in_valid && gr_in_ready;

    // --------------------
    // gradient of the origin
    // --------------------
    // origin is win[W], its right neighbour win[W-1], the pixel below win[0]
    always_comb begin
        if (org_col == LAST_COL || org_row == LAST_ROW) begin
            gr_in_data = '0;
        end else begin
            gr_in_data.gx = ig_pkg::comp_t'(win[W-1]) - ig_pkg::comp_t'(win[W]);
            gr_in_data.gy = ig_pkg::comp_t'(win[0]) - ig_pkg::comp_t'(win[W]);
        end
    end

    always_ff @(posedge clk) begin
        if (pix_fire) begin
            win[0] <= pix_data;
            for (int i = 1; i <= W; i++) begin
                win[i] <= win[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_cnt   <= '0;
            win_full <= 1'b0;
            drain    <= 1'b0;
            org_col  <= '0;
            org_row  <= '0;
        end else begin
            if (pix_fire) begin
                in_cnt <= in_cnt + 1'b1;
                if (in_cnt == FILL_PIX) begin
                    win_full <= 1'b1;
                end
                // remaining origins have no pixel below
                if (in_cnt == LAST_PIX) begin
                    drain <= 1'b1;
                end
            end
            if (gr_fire) begin
                if (org_col == LAST_COL) begin
                    org_col <= '0;
                    org_row <= (org_row == LAST_ROW) ? '0 : org_row + 1'b1;
                    if (drain && org_row == LAST_ROW) begin
                        drain <= 1'b0;
                    end
                end else begin
                    org_col <= org_col + 1'b1;
                end
            end
        end
    end

    pipe_skid #(
        .payload_t (ig_pkg::grad_t)
    ) u_grad_skid (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (gr_in_valid),
        .in_ready  (gr_in_ready),
        .in_data   (gr_in_data),
        .out_valid (gr_valid),
        .out_ready (gr_ready),
        .out_data  (gr_data),
        .level     ()
    );

endmodule

`default_nettype wire

//--- grad_writer.sv
`timescale 1ns/1ns
`default_nettype none

`include "ig_defines.svh"

module grad_writer (
    input  logic          clk,
    input  logic          reset,
    input  logic          gr_valid,
    output logic          gr_ready,
    input  ig_pkg::grad_t gr_data,
    output logic          grad_wr,
    output ig_pkg::addr_t grad_addr,
    output ig_pkg::grad_t grad_do,
    input  logic          grad_ready,
    output logic          done
);

    localparam int unsigned NUM_PIX = `IG_IMG_W * `IG_IMG_H;
    localparam ig_pkg::addr_t LAST_ADDR = ig_pkg::addr_t'(NUM_PIX - 1);

    logic wr_fire;
    logic gr_fire;

    assign wr_fire  = grad_wr && grad_ready;
    // register is free when empty or leaving this cycle
    assign gr_ready = !grad_wr || grad_ready;
    assign gr_fire  = gr_valid && gr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr   <= 1'b0;
            grad_addr <= '0;
            done      <= 1'b0;
        end else begin
            if (gr_fire) begin
                grad_wr <= 1'b1;
            end else if (wr_fire) begin
                grad_wr <= 1'b0;
            end
            // address moves on only once the write is taken
            if (wr_fire) begin
                grad_addr <= grad_addr + 1'b1;
                if (grad_addr == LAST_ADDR) begin
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gr_fire) begin
            grad_do <= gr_data;
        end
    end

endmodule

`default_nettype wire

//--- ig.f
+incdir+.
ig_pkg.sv
pipe_skid.sv
img_reader.sv
grad_compute.sv
grad_writer.sv
ig_top.sv
ig_asserts.sv
tb_ig.sv

//--- ig_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module ig_asserts (
    input logic           clk,
    input logic           reset,
    input logic           img_rd,
    input logic           grad_wr,
    input ig_pkg::addr_t  grad_addr,
    input ig_pkg::grad_t  grad_do,
    input logic           grad_ready,
    input logic           done
);

    // number of failed assertions so far
    int fail_cnt = 0;

    // --------------------
    // gradient memory port
    // --------------------
    // a refused write is offered again unchanged
    property grad_hold_p;
        @(posedge clk) disable iff (reset)
            (grad_wr && !grad_ready) |=>
                (grad_wr && $stable(grad_addr) && $stable(grad_do));
    endproperty

    a_grad_hold: assert property (grad_hold_p)
        else begin
            $error("grad write changed while grad_ready was low");
            fail_cnt++;
        end

    // --------------------
    // completion
    // --------------------
    a_done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else begin
            $error("done fell before reset");
            fail_cnt++;
        end

    a_no_read_after_done: assert property (@(posedge clk) disable iff (reset) done |-> !img_rd)
        else begin
            $error("image read issued after done");
            fail_cnt++;
        end

endmodule

bind ig_top ig_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .img_rd     (img_rd),
    .grad_wr    (grad_wr),
    .grad_addr  (grad_addr),
    .grad_do    (grad_do),
    .grad_ready (grad_ready),
    .done       (done)
);

`default_nettype wire

//--- ig_defines.svh
`ifndef IG_DEFINES_SVH
`define IG_DEFINES_SVH

// --------------------
// image geometry
// --------------------

// square image stored in raster order
`define IG_IMG_W 16
`define IG_IMG_H 16

// must cover IG_IMG_W * IG_IMG_H entries
`define IG_ADDR_W 8

// --------------------
// data widths
// --------------------

`define IG_PIX_W 8
// one sign bit plus headroom for a full-range pixel difference
`define IG_COMP_W 10

`endif

//--- ig_pkg.sv
`default_nettype none

`include "ig_defines.svh"

package ig_pkg;

    // greyscale pixel from image memory
    typedef logic [`IG_PIX_W-1:0] pixel_t;

    // one signed gradient component
    typedef logic signed [`IG_COMP_W-1:0] comp_t;

    // gx in the upper half, gy in the lower half
    typedef struct packed {
        comp_t gx;
        comp_t gy;
    } grad_t;

    // shared by image and gradient memories
    typedef logic [`IG_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

//--- ig_top.sv
`timescale 1ns/1ns
`default_nettype none

module ig_top (
    input  logic           clk,
    input  logic           reset,

    // image memory
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,

    // gradient memory
    output logic           grad_wr,
    output ig_pkg::addr_t  grad_addr,
    output ig_pkg::grad_t  grad_do,
    input  logic           grad_ready,

    output logic           done
);

    // --------------------
    // pixel stream
    // --------------------
    logic           pix_valid;
    logic           pix_ready;
    ig_pkg::pixel_t pix_data;

    // --------------------
    // gradient stream
    // --------------------
    logic          gr_valid;
    logic          gr_ready;
    ig_pkg::grad_t gr_data;

    img_reader u_img_reader (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data)
    );

    grad_compute u_grad_compute (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .gr_valid  (gr_valid),
        .gr_ready  (gr_ready),
        .gr_data   (gr_data)
    );

    grad_writer u_grad_writer (
        .clk        (clk),
        .reset      (reset),
        .gr_valid   (gr_valid),
        .gr_ready   (gr_ready),
        .gr_data    (gr_data),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- img_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "ig_defines.svh"

module img_reader (
    input  logic           clk,
    input  logic           reset,
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,
    output logic           pix_valid,
    input  logic           pix_ready,
    output ig_pkg::pixel_t pix_data
);

    localparam int unsigned NUM_PIX = `IG_IMG_W * `IG_IMG_H;
    localparam ig_pkg::addr_t LAST_ADDR = ig_pkg::addr_t'(NUM_PIX - 1);

    ig_pkg::addr_t rd_addr;
    logic          rd_started;
    logic          rd_active;
    logic          in_flight;

    logic [1:0] skid_level;
    logic       pix_pop;
    logic [2:0] occupancy;

    // entries held next cycle are those held now plus the returning read minus a pop
    assign pix_pop   = pix_valid && pix_ready;
    assign occupancy = {1'b0, skid_level} + {2'b00, in_flight} - {2'b00, pix_pop};

    // a read is only issued if its pixel is sure to find a free entry
    assign img_rd   = rd_active && (occupancy < 3'd2);
    assign img_addr = rd_addr;

    // --------------------
    // read sequencing
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_addr    <= '0;
            rd_started <= 1'b0;
            rd_active  <= 1'b0;
            in_flight  <= 1'b0;
        end else begin
            // memory answers one cycle after the read
            in_flight <= img_rd;
            if (!rd_started) begin
                rd_started <= 1'b1;
                rd_active  <= 1'b1;
            end else if (img_rd) begin
                if (rd_addr == LAST_ADDR) begin
                    rd_active <= 1'b0;
                end
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // in_ready unused because room is reserved before each read
    pipe_skid #(
        .payload_t (ig_pkg::pixel_t)
    ) u_pix_skid (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_flight),
        .in_ready  (),
        .in_data   (img_di),
        .out_valid (pix_valid),
        .out_ready (pix_ready),
        .out_data  (pix_data),
        .level     (skid_level)
    );

endmodule

`default_nettype wire

//--- pipe_skid.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data,
    output logic [1:0] level
);

    // second entry, only used while the output is stalled
    logic     spare_valid;
    payload_t spare_data;

    logic out_free;
    logic in_fire;

    // output register can take a new word this cycle
    assign out_free = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // space is left as long as the spare entry is empty
    assign in_ready = !spare_valid;
    assign level    = {1'b0, out_valid} + {1'b0, spare_valid};

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
        end else if (out_free) begin
            if (spare_valid) begin
                out_valid   <= 1'b1;
                spare_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_fire) begin
            spare_valid <= 1'b1;
        end
    end

    // --------------------
    // payload
    // --------------------
    always_ff @(posedge clk) begin
        if (out_free) begin
            if (spare_valid) begin
                out_data <= spare_data;
            end else if (in_valid) begin
                out_data <= in_data;
            end
        end else if (in_fire) begin
            spare_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- tb_ig.sv
`timescale 1ns/1ns
`default_nettype none

`include "ig_defines.svh"

module tb_ig;

    localparam int W          = `IG_IMG_W;
    localparam int H          = `IG_IMG_H;
    localparam int NUM_PIX    = W * H;
    localparam int COMP_MASK  = (1 << `IG_COMP_W) - 1;
    localparam int STALL_LEN  = 1024;
    localparam int DONE_LIMIT = 20000;
    localparam int NUM_ROWS   = 8;

    localparam int PAT_CONST = 0;
    localparam int PAT_HRAMP = 1;
    localparam int PAT_VRAMP = 2;
    localparam int PAT_CHECK = 3;
    localparam int PAT_RAND  = 4;

    // stimulus table of image pattern and grad_ready stall percentage
    int pat_tbl [0:NUM_ROWS-1] = '{PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_CHECK,
                                   PAT_CHECK, PAT_RAND, PAT_RAND, PAT_RAND};
    int stall_tbl [0:NUM_ROWS-1] = '{0, 0, 30, 0, 70, 0, 30, 70};

    logic           clk;
    logic           reset;
    logic           img_rd;
    ig_pkg::addr_t  img_addr;
    ig_pkg::pixel_t img_di;
    logic           grad_wr;
    ig_pkg::addr_t  grad_addr;
    ig_pkg::grad_t  grad_do;
    logic           grad_ready;
    logic           done;

    ig_pkg::pixel_t img_mem  [0:NUM_PIX-1];
    ig_pkg::pixel_t rand_img [0:NUM_PIX-1];
    logic [31:0]    grad_mem [0:NUM_PIX-1];
    logic [31:0]    golden   [0:NUM_PIX-1];
    int             wr_count [0:NUM_PIX-1];
    bit             stall_map [0:STALL_LEN-1];

    int            rd_cnt;
    int            wr_cnt;
    int            stall_idx;
    logic          rd_pend;
    ig_pkg::addr_t rd_pend_addr;

    ig_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            report_failure("value mismatch");
        end
    endtask

    // gx is right minus pixel, gy is below minus pixel, zero on the far edges
    function automatic logic [31:0] expected_grad(input int idx);
        int col;
        int row;
        int gx;
        int gy;
        col = idx % W;
        row = idx / W;
        if (col == W - 1 || row == H - 1) begin
            return 32'd0;
        end
        gx = int'(img_mem[idx+1]) - int'(img_mem[idx]);
        gy = int'(img_mem[idx+W]) - int'(img_mem[idx]);
        return 32'(((gx & COMP_MASK) << `IG_COMP_W) | (gy & COMP_MASK));
    endfunction

    // --------------------
    // memory models
    // --------------------
    // grad_ready is updated first, so a recorded write is the one taken next edge
    always @(negedge clk) begin
        grad_ready = !stall_map[stall_idx];
        stall_idx  = (stall_idx + 1) % STALL_LEN;
        if (rd_pend) begin
            img_di = img_mem[rd_pend_addr];
        end
        rd_pend      = (img_rd === 1'b1);
        rd_pend_addr = img_addr;
        if (img_rd === 1'b1) begin
            check(img_addr, rd_cnt, "read address order");
            rd_cnt++;
        end
        if (grad_wr === 1'b1 && grad_ready) begin
            check(grad_addr, wr_cnt, "write address order");
            grad_mem[grad_addr] = grad_do;
            wr_count[grad_addr]++;
            wr_cnt++;
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_cnt != 0) begin
            report_failure("a concurrent assertion in the bound checker failed");
        end
    end

    task automatic fill_image(input int pattern);
        int col;
        int row;
        for (int i = 0; i < NUM_PIX; i++) begin
            col = i % W;
            row = i / W;
            case (pattern)
                PAT_CONST: img_mem[i] = 8'd77;
                PAT_HRAMP: img_mem[i] = 8'(col * 17);
                PAT_VRAMP: img_mem[i] = 8'(255 - row * 17);
                PAT_CHECK: img_mem[i] = ((row + col) % 2 == 1) ? 8'd255 : 8'd0;
                default:   img_mem[i] = rand_img[i];
            endcase
        end
    endtask

    task automatic fill_stalls(input int pct);
        for (int i = 0; i < STALL_LEN; i++) begin
            stall_map[i] = ($urandom_range(99) < pct);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rd_cnt = 0;
        wr_cnt = 0;
        for (int i = 0; i < NUM_PIX; i++) begin
            wr_count[i] = 0;
            grad_mem[i] = 'x;
        end
        reset = 1'b0;
        check(img_rd, 0, "img_rd after reset");
        check(grad_wr, 0, "grad_wr after reset");
        check(done, 0, "done after reset");
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_LIMIT) begin
                report_failure("timeout: done did not rise after the image was read");
            end
        end
        check(wr_cnt, NUM_PIX, "writes before done");
    endtask

    task automatic check_results(input int pattern, input int pct);
        // done must hold and nothing more may be read or written
        repeat (8) begin
            @(negedge clk);
            check(done, 1, "done held high");
        end
        check(rd_cnt, NUM_PIX, "image read count");
        check(wr_cnt, NUM_PIX, "gradient write count");
        for (int i = 0; i < NUM_PIX; i++) begin
            check(wr_count[i], 1, $sformatf("write count at address %0d", i));
            check(grad_mem[i], expected_grad(i), $sformatf("gradient at address %0d", i));
            if (pattern == PAT_RAND) begin
                if (pct == 0) begin
                    golden[i] = grad_mem[i];
                end else begin
                    check(grad_mem[i], golden[i], $sformatf("stalled run at %0d", i));
                end
            end
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset      = 1'b1;
        grad_ready = 1'b1;
        img_di     = '0;
        rd_pend    = 1'b0;
        stall_idx  = 0;
        void'($urandom(32'h4403_7f23));
        for (int i = 0; i < NUM_PIX; i++) begin
            rand_img[i] = 8'($urandom_range(255));
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            fill_image(pat_tbl[r]);
            fill_stalls(stall_tbl[r]);
            apply_reset();
            wait_for_done();
            check_results(pat_tbl[r], stall_tbl[r]);
        end
        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            report_failure("a concurrent assertion failed near the end of the run");
        end
        $finish;
    end

endmodule

`default_nettype wire
